//--- logic/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // ----------------------------------------
    // Table sizes
    // ----------------------------------------

    // BTB index from group address bits [10:3]
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_ENTRIES = 1 << BTB_IDX_W;

    // Folded tag width
    localparam int TAG_W       = 15;

    // Direction counters indexed by bits [12:3]
    localparam int PHT_IDX_W   = 10;
    localparam int PHT_ENTRIES = 1 << PHT_IDX_W;
    // Weakly not taken
    localparam logic [1:0] PHT_INIT = 2'b01;

    // Return stack, power of two for pointer wrap
    localparam int RAS_DEPTH   = 8;
    localparam int RAS_PTR_W   = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_W   = $clog2(RAS_DEPTH + 1);

    // ----------------------------------------
    // Types
    // ----------------------------------------

    // Word address, byte offset dropped
    typedef logic [31:2] pc_t;

    // Branch kind, BR_COND doubles as the miss type
    typedef enum logic [1:0] {
        BR_COND   = 2'd0,
        BR_JUMP   = 2'd1,
        BR_CALL   = 2'd2,
        BR_RETURN = 2'd3
    } br_type_e;

    // Fetch group lookup
    typedef struct packed {
        logic      valid;
        pc_t       pc;
    } pred_req_t;

    // Prediction answer, one cycle after the request
    typedef struct packed {
        logic      valid;
        logic      hit;
        logic      fsc;
        br_type_e  br_type;
        logic      taken;
        pc_t       target;
    } pred_rsp_t;

    // Training from the back end, pc is the branch itself
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        pc_t       target;
        br_type_e  br_type;
        logic      taken;
    } bpu_upd_t;

    // BTB payload, valid bit lives in flops
    typedef struct packed {
        logic              fsc;
        logic [TAG_W-1:0]  tag;
        pc_t               bta;
        br_type_e          br_type;
    } btb_entry_t;

    localparam int BTB_ENTRY_W = $bits(btb_entry_t);

    // Fold upper address bits onto the index region
    function automatic logic [TAG_W-1:0] bpu_tag(pc_t pc);
        return pc[31:17] ^ pc[17:3];
    endfunction

endpackage

`default_nettype wire

//--- logic/bpu_sdpram.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_sdpram #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 48
) (
    input  logic              clk,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output logic [DATA_W-1:0] rdata_o
);

    // Storage array, maps to block RAM
    logic [DATA_W-1:0] mem_q [2**ADDR_W];

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    // Takes effect at the edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Registered read
    // Same-address write in this cycle is not visible yet
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

`default_nettype wire

//--- logic/bpu_btb.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_btb (
    input  logic               clk,
    input  logic               rst_n,
    input  bpu_pkg::pc_t       rd_pc_i,
    input  bpu_pkg::bpu_upd_t  upd_i,
    output logic               hit_o,
    output logic               fsc_o,
    output bpu_pkg::pc_t       bta_o,
    output bpu_pkg::br_type_e  br_type_o
);

    import bpu_pkg::*;

    // Read side
    logic [BTB_IDX_W-1:0]  rd_idx;
    pc_t                   rd_pc_q;
    logic [TAG_W-1:0]      lookup_tag;
    btb_entry_t            rd_entry;
    logic                  rd_valid_q;
    logic                  hit;

    // Write side
    logic                  wr_en;
    logic [BTB_IDX_W-1:0]  wr_idx;
    btb_entry_t            wr_entry;

    // Per-entry valid flags
    logic [BTB_ENTRIES-1:0] valid_q;

    // ----------------------------------------
    // Index and write data
    // ----------------------------------------

    assign rd_idx = rd_pc_i[BTB_IDX_W+2:3];
    assign wr_idx = upd_i.pc[BTB_IDX_W+2:3];

    // Only taken branches get allocated
    assign wr_en = upd_i.valid & upd_i.taken;

    // Slot from address bit 2 of the branch
    always_comb begin
        wr_entry.fsc     = upd_i.pc[2];
        wr_entry.tag     = bpu_tag(upd_i.pc);
        wr_entry.bta     = upd_i.target;
        wr_entry.br_type = upd_i.br_type;
    end

    // Entry payload
    bpu_sdpram #(
        .ADDR_W (BTB_IDX_W),
        .DATA_W (BTB_ENTRY_W)
    ) u_ram (
        .clk     (clk),
        .we_i    (wr_en),
        .waddr_i (wr_idx),
        .wdata_i (wr_entry),
        .raddr_i (rd_idx),
        .rdata_o (rd_entry)
    );

    // ----------------------------------------
    // Valid bits
    // ----------------------------------------

    // Cleared on reset, set on allocation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Read alongside the RAM, old value on collision
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_idx];
        end
    end

    // Lookup address for the tag compare
    always_ff @(posedge clk) begin
        rd_pc_q <= rd_pc_i;
    end

    // ----------------------------------------
    // Lookup result
    // ----------------------------------------

    assign lookup_tag = bpu_tag(rd_pc_q);
    assign hit        = rd_valid_q && (rd_entry.tag == lookup_tag);

    assign hit_o     = hit;
    // Miss falls through to slot 0 of the next group
    assign fsc_o     = hit ? rd_entry.fsc : 1'b0;
    assign bta_o     = hit ? rd_entry.bta : {rd_pc_q[31:3] + 29'd1, 1'b0};
    assign br_type_o = hit ? rd_entry.br_type : BR_COND;

endmodule

`default_nettype wire

//--- logic/bpu_bimodal.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_bimodal (
    input  logic               clk,
    input  logic               rst_n,
    input  bpu_pkg::pc_t       rd_pc_i,
    input  bpu_pkg::bpu_upd_t  upd_i,
    output logic               taken_o
);

    import bpu_pkg::*;

    // Two-bit counters, MSB is the direction
    logic [1:0] cnt_q [PHT_ENTRIES];

    logic [PHT_IDX_W-1:0] rd_idx;
    logic [PHT_IDX_W-1:0] wr_idx;
    logic                 wr_en;
    logic [1:0]           cnt_cur;
    logic [1:0]           cnt_nxt;
    logic                 taken_q;

    assign rd_idx = rd_pc_i[PHT_IDX_W+2:3];
    assign wr_idx = upd_i.pc[PHT_IDX_W+2:3];

    // Conditional branches only
    assign wr_en = upd_i.valid && (upd_i.br_type == BR_COND);

    // ----------------------------------------
    // Saturating next value
    // ----------------------------------------

    always_comb begin
        cnt_cur = cnt_q[wr_idx];
        cnt_nxt = cnt_cur;
        // Hold at 11 and 00
        if (upd_i.taken && (cnt_cur != 2'b11)) begin
            cnt_nxt = cnt_cur + 2'd1;
        end else if (!upd_i.taken && (cnt_cur != 2'b00)) begin
            cnt_nxt = cnt_cur - 2'd1;
        end
    end

    // ----------------------------------------
    // Counter table
    // ----------------------------------------

    // All entries back to weakly not taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                cnt_q[i] <= PHT_INIT;
            end
        end else if (wr_en) begin
            cnt_q[wr_idx] <= cnt_nxt;
        end
    end

    // Registered lookup, sees pre-update contents
    always_ff @(posedge clk) begin
        taken_q <= cnt_q[rd_idx][1];
    end

    assign taken_o = taken_q;

endmodule

`default_nettype wire

//--- logic/bpu_ras.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_ras (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push_i,
    input  bpu_pkg::pc_t  push_addr_i,
    input  logic          pop_i,
    output logic          empty_o,
    output bpu_pkg::pc_t  top_o
);

    import bpu_pkg::*;

    // Return addresses, no reset on contents
    pc_t stack_q [RAS_DEPTH];

    // Slot of the current top
    logic [RAS_PTR_W-1:0] top_q;
    logic [RAS_PTR_W-1:0] top_inc;
    logic [RAS_PTR_W-1:0] top_dec;

    // Live entries, saturates at RAS_DEPTH
    logic [RAS_CNT_W-1:0] cnt_q;
    logic                 full;
    logic                 empty;

    assign top_inc = top_q + 1'b1;
    assign top_dec = top_q - 1'b1;

    assign full  = (cnt_q == RAS_CNT_W'(RAS_DEPTH));
    assign empty = (cnt_q == '0);

    // ----------------------------------------
    // Pointer and count
    // ----------------------------------------

    // Push wins if both are raised
    // Pop on empty is dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= '0;
            cnt_q <= '0;
        end else if (push_i) begin
            top_q <= top_inc;
            // Full stack drops its oldest entry
            if (!full) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pop_i && !empty) begin
            top_q <= top_dec;
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Wrapped pointer lands on the oldest slot when full
    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[top_inc] <= push_addr_i;
        end
    end

    assign empty_o = empty;
    // Combinational top
    assign top_o   = stack_q[top_q];

endmodule

`default_nettype wire

//--- logic/bpu_top.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  bpu_pkg::pred_req_t  pred_req_i,
    input  bpu_pkg::bpu_upd_t   upd_i,
    output bpu_pkg::pred_rsp_t  pred_rsp_o
);

    import bpu_pkg::*;

    // Response cycle state
    logic      rsp_valid_q;
    pc_t       rsp_pc_q;
    pc_t       fall_thru;
    pc_t       ret_addr;

    // BTB result
    logic      btb_hit;
    logic      btb_fsc;
    pc_t       btb_bta;
    br_type_e  btb_type;

    // Direction
    logic      pht_taken;

    // Return stack
    logic      ras_push;
    logic      ras_pop;
    logic      ras_empty;
    pc_t       ras_top;

    // ----------------------------------------
    // Predictor blocks
    // ----------------------------------------

    bpu_btb u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_pc_i   (pred_req_i.pc),
        .upd_i     (upd_i),
        .hit_o     (btb_hit),
        .fsc_o     (btb_fsc),
        .bta_o     (btb_bta),
        .br_type_o (btb_type)
    );

    bpu_bimodal u_bimodal (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_pc_i (pred_req_i.pc),
        .upd_i   (upd_i),
        .taken_o (pht_taken)
    );

    bpu_ras u_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ras_push),
        .push_addr_i (ret_addr),
        .pop_i       (ras_pop),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

    // ----------------------------------------
    // Request pipeline
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= pred_req_i.valid;
        end
    end

    // Group address of the response cycle
    always_ff @(posedge clk) begin
        rsp_pc_q <= pred_req_i.pc;
    end

    // Next group, slot 0
    assign fall_thru = {rsp_pc_q[31:3] + 29'd1, 1'b0};
    // Branch slot plus one instruction
    assign ret_addr  = {rsp_pc_q[31:3], btb_fsc} + 30'd1;

    // ----------------------------------------
    // Response glue
    // ----------------------------------------

    always_comb begin
        pred_rsp_o.valid   = rsp_valid_q;
        pred_rsp_o.hit     = btb_hit;
        pred_rsp_o.fsc     = btb_fsc;
        pred_rsp_o.br_type = btb_type;
        pred_rsp_o.taken   = 1'b0;
        pred_rsp_o.target  = fall_thru;
        ras_push           = 1'b0;
        ras_pop            = 1'b0;
        // Miss keeps the fall-through defaults
        if (btb_hit) begin
            unique case (btb_type)
                BR_COND: begin
                    pred_rsp_o.taken  = pht_taken;
                    pred_rsp_o.target = pht_taken ? btb_bta : fall_thru;
                end
                BR_JUMP: begin
                    pred_rsp_o.taken  = 1'b1;
                    pred_rsp_o.target = btb_bta;
                end
                BR_CALL: begin
                    pred_rsp_o.taken  = 1'b1;
                    pred_rsp_o.target = btb_bta;
                    ras_push          = rsp_valid_q;
                end
                BR_RETURN: begin
                    pred_rsp_o.taken  = 1'b1;
                    // Empty stack falls back on the stored target
                    pred_rsp_o.target = ras_empty ? btb_bta : ras_top;
                    ras_pop           = rsp_valid_q;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sim/bpu_assert.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_assert (
    input logic                clk,
    input logic                rst_n,
    input bpu_pkg::pred_req_t  req_i,
    input bpu_pkg::pred_rsp_t  rsp_i
);

    // Failed assertions so far, read by the testbench
    int unsigned err_cnt = 0;

    // ----------------------------------------
    // Response timing
    // ----------------------------------------

    // One response per request, one cycle later
    a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (rsp_i.valid == $past(req_i.valid)))
    else begin
        $error("response valid does not follow request valid by one cycle");
        err_cnt++;
    end

    // A miss is never predicted taken
    a_miss_not_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_i.valid && !rsp_i.hit) |-> !rsp_i.taken)
    else begin
        $error("taken response without a BTB hit");
        err_cnt++;
    end

    // Reset cycle clears the response
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !rsp_i.valid)
    else begin
        $error("response valid in the cycle after reset");
        err_cnt++;
    end

endmodule

bind bpu_top bpu_assert u_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .req_i (pred_req_i),
    .rsp_i (pred_rsp_o)
);

`default_nettype wire

//--- sim/bpu_tb.sv
`default_nettype none
`timescale 1ns/1ns

module bpu_tb;

    import bpu_pkg::*;

    logic       clk;
    logic       rst_n;
    pred_req_t  req_drv;
    bpu_upd_t   upd_drv;
    pred_rsp_t  rsp_mon;

    logic [31:0] lfsr_q;
    string       test_name;
    // Response to the request of the previous cycle
    pred_rsp_t   last_rsp;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------

    btb_entry_t  m_btb [BTB_ENTRIES];
    logic        m_vld [BTB_ENTRIES];
    logic [1:0]  m_pht [PHT_ENTRIES];
    pc_t         m_stk [RAS_DEPTH];
    int          m_top;
    int          m_depth;

    // Lookup taken when the request was issued
    logic        pend_valid;
    pc_t         pend_pc;
    logic        snap_hit;
    btb_entry_t  snap_ent;
    logic        snap_taken;

    bpu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_req_i (req_drv),
        .upd_i      (upd_drv),
        .pred_rsp_o (rsp_mon)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Galois LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_q[0]) begin
                lfsr_q = (lfsr_q >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_q = lfsr_q >> 1;
            end
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // ----------------------------------------
    // Stimulus and expectation helpers
    // ----------------------------------------

    function automatic pred_req_t make_req(input pc_t pc);
        pred_req_t r;
        r.valid = 1'b1;
        r.pc    = pc;
        return r;
    endfunction

    function automatic pred_req_t no_req();
        return '0;
    endfunction

    function automatic bpu_upd_t make_upd(input pc_t pc, input pc_t tgt,
                                          input br_type_e t, input logic tk);
        bpu_upd_t u;
        u.valid   = 1'b1;
        u.pc      = pc;
        u.target  = tgt;
        u.br_type = t;
        u.taken   = tk;
        return u;
    endfunction

    function automatic bpu_upd_t no_upd();
        return '0;
    endfunction

    // Slot 0 of the group 8 bytes on
    function automatic pc_t next_group(input pc_t pc);
        return {pc[31:3], 1'b0} + 30'd2;
    endfunction

    function automatic logic [TAG_W-1:0] fold_tag(input pc_t pc);
        return pc[31:17] ^ pc[17:3];
    endfunction

    function automatic pred_rsp_t miss_rsp(input pc_t pc);
        pred_rsp_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.br_type = BR_COND;
        r.target  = next_group(pc);
        return r;
    endfunction

    function automatic pred_rsp_t hit_rsp(input logic fsc, input br_type_e t,
                                          input logic tk, input pc_t tgt);
        pred_rsp_t r;
        r.valid   = 1'b1;
        r.hit     = 1'b1;
        r.fsc     = fsc;
        r.br_type = t;
        r.taken   = tk;
        r.target  = tgt;
        return r;
    endfunction

    // Random group and slot within a 32-group window
    function automatic pc_t pool_pc(input logic [28:0] grp);
        logic [31:0] off;
        logic [31:0] slot;
        off  = rand_bits(5);
        slot = rand_bits(1);
        return {grp + off[28:0], slot[0]};
    endfunction

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic value_fail(input string name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL %s: %s expected %h actual %h", name, field, exp, act);
        abort_run();
    endtask

    task automatic check_type(input string name, input br_type_e exp, input br_type_e act);
        if (exp !== act) begin
            $display("FAIL %s: br_type expected %s actual %s", name, exp.name(), act.name());
            abort_run();
        end
    endtask

    // Fields other than valid only matter on a valid response
    task automatic check_rsp(input string name, input pred_rsp_t exp, input pred_rsp_t act);
        if (exp.valid !== act.valid) value_fail(name, "valid", exp.valid, act.valid);
        if (exp.valid) begin
            if (exp.hit !== act.hit) value_fail(name, "hit", exp.hit, act.hit);
            if (exp.fsc !== act.fsc) value_fail(name, "fsc", exp.fsc, act.fsc);
            check_type(name, exp.br_type, act.br_type);
            if (exp.taken !== act.taken) value_fail(name, "taken", exp.taken, act.taken);
            if (exp.target !== act.target) value_fail(name, "target", exp.target, act.target);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    task automatic model_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) m_vld[i] = 1'b0;
        for (int i = 0; i < PHT_ENTRIES; i++) m_pht[i] = 2'b01;
        m_top      = 0;
        m_depth    = 0;
        pend_valid = 1'b0;
    endtask

    // Tables as they stand before this cycle's update
    task automatic model_lookup(input pred_req_t req);
        int idx;
        idx        = req.pc[BTB_IDX_W+2:3];
        pend_valid = req.valid;
        pend_pc    = req.pc;
        snap_hit   = m_vld[idx] && (m_btb[idx].tag == fold_tag(req.pc));
        snap_ent   = m_btb[idx];
        snap_taken = m_pht[req.pc[PHT_IDX_W+2:3]][1];
    endtask

    task automatic model_train(input bpu_upd_t upd);
        int idx;
        int p;
        idx = upd.pc[BTB_IDX_W+2:3];
        p   = upd.pc[PHT_IDX_W+2:3];
        if (upd.valid && upd.taken) begin
            m_btb[idx].fsc     = upd.pc[2];
            m_btb[idx].tag     = fold_tag(upd.pc);
            m_btb[idx].bta     = upd.target;
            m_btb[idx].br_type = upd.br_type;
            m_vld[idx]         = 1'b1;
        end
        // Saturating two-bit counter
        if (upd.valid && (upd.br_type == BR_COND)) begin
            if (upd.taken && (m_pht[p] != 2'b11)) m_pht[p] = m_pht[p] + 2'd1;
            if (!upd.taken && (m_pht[p] != 2'b00)) m_pht[p] = m_pht[p] - 2'd1;
        end
    endtask

    // Expected response for the pending request and the stack move it causes
    task automatic model_respond(output pred_rsp_t exp);
        exp         = miss_rsp(pend_pc);
        exp.valid   = pend_valid;
        if (pend_valid && snap_hit) begin
            exp.hit     = 1'b1;
            exp.fsc     = snap_ent.fsc;
            exp.br_type = snap_ent.br_type;
            exp.taken   = 1'b1;
            exp.target  = snap_ent.bta;
            case (snap_ent.br_type)
                BR_COND: begin
                    exp.taken = snap_taken;
                    if (!snap_taken) exp.target = next_group(pend_pc);
                end
                BR_CALL: begin
                    // Full stack drops the oldest entry
                    m_top        = (m_top + 1) % RAS_DEPTH;
                    m_stk[m_top] = {pend_pc[31:3], snap_ent.fsc} + 30'd1;
                    if (m_depth < RAS_DEPTH) m_depth++;
                end
                BR_RETURN: begin
                    if (m_depth > 0) begin
                        exp.target = m_stk[m_top];
                        m_top      = (m_top + RAS_DEPTH - 1) % RAS_DEPTH;
                        m_depth--;
                    end
                end
                default: ;
            endcase
        end
    endtask

    // ----------------------------------------
    // Cycle driver
    // ----------------------------------------

    // Checks last cycle's response before driving this cycle's inputs
    task automatic drive_cycle(input pred_req_t req, input bpu_upd_t upd);
        pred_rsp_t exp;
        @(negedge clk);
        if (dut0.u_assert.err_cnt != 0) begin
            $display("A timing assertion on the DUT failed during test %s", test_name);
            abort_run();
        end
        model_respond(exp);
        check_rsp(test_name, exp, rsp_mon);
        last_rsp = rsp_mon;
        model_lookup(req);
        model_train(upd);
        req_drv = req;
        upd_drv = upd;
    endtask

    task automatic request_one(input pc_t pc);
        drive_cycle(make_req(pc), no_upd());
        drive_cycle(no_req(), no_upd());
    endtask

    task automatic train(input bpu_upd_t upd);
        drive_cycle(no_req(), upd);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    task automatic test_reset();
        pc_t pc;
        pc_t prev;
        test_name = "reset_state";
        prev = '0;
        for (int i = 0; i < 16; i++) begin
            pc = pc_t'(rand_bits(30));
            drive_cycle(make_req(pc), no_upd());
            if (i > 0) check_rsp(test_name, miss_rsp(prev), last_rsp);
            prev = pc;
        end
        drive_cycle(no_req(), no_upd());
        check_rsp(test_name, miss_rsp(prev), last_rsp);
    endtask

    task automatic test_btb_fill();
        pc_t pcs [4];
        pc_t tgts [4];
        pc_t pb;
        pc_t tb;
        test_name = "btb_fill_alias";
        for (int i = 0; i < 4; i++) begin
            pcs[i]        = pc_t'(rand_bits(30));
            // Distinct indices
            pcs[i][10:9]  = 2'(i);
            tgts[i]       = pc_t'(rand_bits(30));
            train(make_upd(pcs[i], tgts[i], BR_JUMP, 1'b1));
        end
        for (int i = 0; i < 4; i++) begin
            request_one(pcs[i]);
            check_rsp(test_name, hit_rsp(pcs[i][2], BR_JUMP, 1'b1, tgts[i]), last_rsp);
        end
        // Same index with bit 20 of the tag flipped
        pb     = pcs[0];
        pb[20] = ~pcs[0][20];
        tb     = pc_t'(rand_bits(30));
        request_one(pb);
        check_rsp(test_name, miss_rsp(pb), last_rsp);
        train(make_upd(pb, tb, BR_JUMP, 1'b1));
        request_one(pb);
        check_rsp(test_name, hit_rsp(pb[2], BR_JUMP, 1'b1, tb), last_rsp);
        request_one(pcs[0]);
        check_rsp(test_name, miss_rsp(pcs[0]), last_rsp);
    endtask

    task automatic test_counter();
        // Directions and the counter MSB after each one starting from 01
        bit  dir_seq [15] = '{1, 0, 1, 1, 0, 1, 1, 1, 0, 0, 0, 0, 0, 1, 1};
        bit  exp_seq [15] = '{1, 0, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 1};
        pc_t bc;
        pc_t bt;
        test_name = "counter_training";
        bc = pc_t'(rand_bits(30));
        bt = pc_t'(rand_bits(30));
        request_one(bc);
        check_rsp(test_name, miss_rsp(bc), last_rsp);
        for (int i = 0; i < 15; i++) begin
            train(make_upd(bc, bt, BR_COND, dir_seq[i]));
            request_one(bc);
            check_rsp(test_name, hit_rsp(bc[2], BR_COND, exp_seq[i],
                                         exp_seq[i] ? bt : next_group(bc)), last_rsp);
        end
    endtask

    task automatic test_collision();
        pc_t dc;
        pc_t t1;
        pc_t t2;
        test_name = "read_first_collision";
        dc = pc_t'(rand_bits(30));
        t1 = pc_t'(rand_bits(30));
        t2 = pc_t'(rand_bits(30));
        train(make_upd(dc, t1, BR_JUMP, 1'b1));
        // Lookup and rewrite in one cycle
        drive_cycle(make_req(dc), make_upd(dc, t2, BR_JUMP, 1'b1));
        drive_cycle(make_req(dc), no_upd());
        check_rsp(test_name, hit_rsp(dc[2], BR_JUMP, 1'b1, t1), last_rsp);
        drive_cycle(no_req(), no_upd());
        check_rsp(test_name, hit_rsp(dc[2], BR_JUMP, 1'b1, t2), last_rsp);
    endtask

    task automatic test_call_return();
        pc_t         cs [10];
        pc_t         ct [10];
        pc_t         rs;
        pc_t         rt;
        logic [31:0] r;
        logic [28:0] g;
        test_name = "call_return";
        r = rand_bits(29);
        g = r[28:0];
        // Consecutive groups keep BTB indices apart
        for (int i = 0; i < 10; i++) begin
            r     = rand_bits(1);
            cs[i] = {g + 29'(i), r[0]};
            ct[i] = pc_t'(rand_bits(30));
            train(make_upd(cs[i], ct[i], BR_CALL, 1'b1));
        end
        rs = {g + 29'd20, 1'b1};
        rt = pc_t'(rand_bits(30));
        train(make_upd(rs, rt, BR_RETURN, 1'b1));
        // Three deep and popped in reverse
        for (int i = 0; i < 3; i++) begin
            request_one(cs[i]);
            check_rsp(test_name, hit_rsp(cs[i][2], BR_CALL, 1'b1, ct[i]), last_rsp);
        end
        for (int k = 2; k >= 0; k--) begin
            request_one(rs);
            check_rsp(test_name, hit_rsp(1'b1, BR_RETURN, 1'b1, cs[k] + 30'd1), last_rsp);
        end
        request_one(rs);
        check_rsp(test_name, hit_rsp(1'b1, BR_RETURN, 1'b1, rt), last_rsp);
        // Ten deep so the two oldest are lost
        for (int i = 0; i < 10; i++) begin
            request_one(cs[i]);
        end
        for (int k = 9; k >= 2; k--) begin
            request_one(rs);
            check_rsp(test_name, hit_rsp(1'b1, BR_RETURN, 1'b1, cs[k] + 30'd1), last_rsp);
        end
        request_one(rs);
        check_rsp(test_name, hit_rsp(1'b1, BR_RETURN, 1'b1, rt), last_rsp);
    endtask

    task automatic test_stream();
        pred_req_t   req;
        bpu_upd_t    upd;
        logic [31:0] r;
        logic [28:0] g;
        test_name = "back_to_back_stream";
        r = rand_bits(29);
        g = r[28:0];
        for (int i = 0; i < 200; i++) begin
            req = no_req();
            upd = no_upd();
            if (rand_bits(3) != 32'd0) req = make_req(pool_pc(g));
            if (rand_bits(1) != 32'd0) begin
                upd.valid   = 1'b1;
                upd.pc      = pool_pc(g);
                upd.target  = pc_t'(rand_bits(30));
                r           = rand_bits(2);
                upd.br_type = br_type_e'(r[1:0]);
                r           = rand_bits(1);
                upd.taken   = r[0];
            end
            drive_cycle(req, upd);
        end
        drive_cycle(no_req(), no_upd());
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        req_drv = '0;
        upd_drv = '0;
        rst_n   = 1'b0;
        lfsr_q  = 32'h7ec0_0f9e;
        model_reset();
        // Two reset edges and release on the following falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_btb_fill();
        test_counter();
        test_collision();
        test_call_return();
        test_stream();

        if (dut0.u_assert.err_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("A timing assertion on the DUT failed");
            abort_run();
        end
    end

    // Cycle bounds per test plus reset and a margin
    initial begin : watchdog
        longint limit_ns;
        limit_ns = longint'(2 + 20 + 30 + 60 + 10 + 80 + 210) * 100 + 50_000;
        #(limit_ns);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

endmodule

`default_nettype wire

//--- list.f
logic/bpu_pkg.sv
logic/bpu_sdpram.sv
logic/bpu_btb.sv
logic/bpu_bimodal.sv
logic/bpu_ras.sv
logic/bpu_top.sv
sim/bpu_assert.sv
sim/bpu_tb.sv
